/* build.f */
+incdir+src
src/lc3b_pkg.sv
src/lc3b_regfile.sv
src/lc3b_decode_stage.sv
src/lc3b_execute_stage.sv
src/lc3b_core.sv
verification/lc3b_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the lc3b core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module lc3b_core_tb \
	--Mdir obj_dir \
	-f build.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vlc3b_core_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

/* src/lc3b_cfg.svh */
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// data word width
`define LC3B_WORD_W 16

// register index width
`define LC3B_REG_W 3

// architectural registers
`define LC3B_REG_COUNT 8

`endif

/* src/lc3b_core.sv */
`timescale 1ns/1ps

module lc3b_core (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input lc3b_pkg::lc3b_instr_u instr,
	output logic wb_valid,
	output lc3b_pkg::lc3b_reg wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output lc3b_pkg::lc3b_nzp cc
);
	import lc3b_pkg::*;

	lc3b_reg rf_addr_a;
	lc3b_reg rf_addr_b;
	lc3b_word rf_data_a;
	lc3b_word rf_data_b;

	logic ex_valid;
	lc3b_alu_op ex_op;
	lc3b_reg ex_dest;
	lc3b_reg ex_sr1;
	lc3b_reg ex_sr2;
	logic ex_use_sr2;
	lc3b_word ex_a;
	lc3b_word ex_b;

	lc3b_decode_stage u_decode (
		.clk,
		.rst_n,
		.instr_valid,
		.instr,
		.rf_addr_a,
		.rf_addr_b,
		.rf_data_a,
		.rf_data_b,
		.ex_valid,
		.ex_op,
		.ex_dest,
		.ex_sr1,
		.ex_sr2,
		.ex_use_sr2,
		.ex_a,
		.ex_b
	);

	lc3b_execute_stage u_execute (
		.clk,
		.rst_n,
		.ex_valid,
		.ex_op,
		.ex_dest,
		.ex_sr1,
		.ex_sr2,
		.ex_use_sr2,
		.ex_a,
		.ex_b,
		.wb_valid,
		.wb_dest,
		.wb_data,
		.cc
	);

	// write port fed straight from EX/WB
	lc3b_regfile u_regfile (
		.clk,
		.rst_n,
		.we(wb_valid),
		.waddr(wb_dest),
		.wdata(wb_data),
		.raddr_a(rf_addr_a),
		.raddr_b(rf_addr_b),
		.rdata_a(rf_data_a),
		.rdata_b(rf_data_b)
	);

endmodule

/* src/lc3b_decode_stage.sv */
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module lc3b_decode_stage (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input lc3b_pkg::lc3b_instr_u instr,
	output lc3b_pkg::lc3b_reg rf_addr_a,
	output lc3b_pkg::lc3b_reg rf_addr_b,
	input lc3b_pkg::lc3b_word rf_data_a,
	input lc3b_pkg::lc3b_word rf_data_b,
	output logic ex_valid,
	output lc3b_pkg::lc3b_alu_op ex_op,
	output lc3b_pkg::lc3b_reg ex_dest,
	output lc3b_pkg::lc3b_reg ex_sr1,
	output lc3b_pkg::lc3b_reg ex_sr2,
	output logic ex_use_sr2,
	output lc3b_pkg::lc3b_word ex_a,
	output lc3b_pkg::lc3b_word ex_b
);
	import lc3b_pkg::*;

	logic supported;
	logic use_sr2;
	lc3b_alu_op alu_op;
	lc3b_word operand_b;
	lc3b_word imm5_sext;
	lc3b_word imm4_zext;

	// sources always sit in the same bit positions
	assign rf_addr_a = instr.reg_form.sr1;
	assign rf_addr_b = instr.reg_form.sr2;

	assign imm5_sext = {{(`LC3B_WORD_W-5){instr.imm_form.imm5[4]}}, instr.imm_form.imm5};
	assign imm4_zext = {{(`LC3B_WORD_W-4){1'b0}}, instr.shf_form.imm4};

	always_comb begin
		supported = 1'b0;
		use_sr2 = 1'b0;
		alu_op = alu_add;
		operand_b = rf_data_b;
		case (instr.reg_form.opcode)
			op_add,
			op_and: begin
				supported = 1'b1;
				if (instr.reg_form.opcode == op_add) begin
					alu_op = alu_add;
				end else begin
					alu_op = alu_and;
				end
				if (instr.imm_form.imm_mode) begin
					operand_b = imm5_sext;
				end else begin
					use_sr2 = 1'b1;
				end
			end
			op_not: begin
				supported = 1'b1;
				alu_op = alu_not;
			end
			op_shf: begin
				supported = 1'b1;
				operand_b = imm4_zext;
				if (!instr.shf_form.right) begin
					alu_op = alu_lshf;
				end else if (instr.shf_form.arith) begin
					alu_op = alu_rshfa;
				end else begin
					alu_op = alu_rshfl;
				end
			end
			default: begin
				// everything else is dropped here
				supported = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= instr_valid && supported;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex_op <= alu_op;
			ex_dest <= instr.reg_form.dr;
			ex_sr1 <= instr.reg_form.sr1;
			ex_sr2 <= instr.reg_form.sr2;
			ex_use_sr2 <= use_sr2;
			ex_a <= rf_data_a;
			ex_b <= operand_b;
		end
	end

	a_instr_known: assert property (
		@(posedge clk) disable iff (!rst_n) instr_valid |-> !$isunknown(instr)
	) else $error("instruction strobed with unknown bits");

endmodule

/* src/lc3b_execute_stage.sv */
`timescale 1ns/1ps

module lc3b_execute_stage (
	input logic clk,
	input logic rst_n,
	input logic ex_valid,
	input lc3b_pkg::lc3b_alu_op ex_op,
	input lc3b_pkg::lc3b_reg ex_dest,
	input lc3b_pkg::lc3b_reg ex_sr1,
	input lc3b_pkg::lc3b_reg ex_sr2,
	input logic ex_use_sr2,
	input lc3b_pkg::lc3b_word ex_a,
	input lc3b_pkg::lc3b_word ex_b,
	output logic wb_valid,
	output lc3b_pkg::lc3b_reg wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output lc3b_pkg::lc3b_nzp cc
);
	import lc3b_pkg::*;

	logic fwd_a;
	logic fwd_b;
	lc3b_word op_a;
	lc3b_word op_b;
	logic [3:0] shamt;
	lc3b_word result;
	lc3b_nzp cc_next;

	// regfile read missed the instruction still in EX/WB
	assign fwd_a = wb_valid && (wb_dest == ex_sr1);
	assign fwd_b = ex_use_sr2 && wb_valid && (wb_dest == ex_sr2);

	assign op_a = fwd_a ? wb_data : ex_a;
	assign op_b = fwd_b ? wb_data : ex_b;

	assign shamt = op_b[3:0];

	always_comb begin
		case (ex_op)
			alu_add: begin
				result = op_a + op_b;
			end
			alu_and: begin
				result = op_a & op_b;
			end
			alu_not: begin
				result = ~op_a;
			end
			alu_lshf: begin
				result = op_a << shamt;
			end
			alu_rshfl: begin
				result = op_a >> shamt;
			end
			alu_rshfa: begin
				result = lc3b_word'($signed(op_a) >>> shamt);
			end
			default: begin
				result = op_a;
			end
		endcase
	end

	// gencc
	always_comb begin
		if (result[$bits(lc3b_word)-1]) begin
			cc_next = 3'b100;
		end else if (result == '0) begin
			cc_next = 3'b010;
		end else begin
			cc_next = 3'b001;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			cc <= 3'b010;
		end else begin
			wb_valid <= ex_valid;
			if (ex_valid) begin
				cc <= cc_next;
			end
		end
	end

	// EX/WB payload
	always_ff @(posedge clk) begin
		if (ex_valid) begin
			wb_dest <= ex_dest;
			wb_data <= result;
		end
	end

	a_ex_known: assert property (
		@(posedge clk) disable iff (!rst_n)
			ex_valid |-> !$isunknown({ex_op, ex_dest, ex_sr1, ex_sr2, ex_use_sr2, ex_a, ex_b})
	) else $error("execute received an instruction with unknown fields");

endmodule

/* src/lc3b_pkg.sv */
`include "lc3b_cfg.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

	// negative, zero, positive
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add   = 3'd0,
		alu_and   = 3'd1,
		alu_not   = 3'd2,
		alu_lshf  = 3'd3,
		alu_rshfl = 3'd4,
		alu_rshfa = 3'd5
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_mode;
		logic [1:0] zero;
		lc3b_reg sr2;
	} lc3b_instr_reg_t;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_mode;
		logic [4:0] imm5;
	} lc3b_instr_imm_t;

	// bit 5 arithmetic, bit 4 right
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic arith;
		logic right;
		logic [3:0] imm4;
	} lc3b_instr_shf_t;

	typedef union packed {
		lc3b_instr_reg_t reg_form;
		lc3b_instr_imm_t imm_form;
		lc3b_instr_shf_t shf_form;
	} lc3b_instr_u;

endpackage

/* src/lc3b_regfile.sv */
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module lc3b_regfile (
	input logic clk,
	input logic rst_n,
	input logic we,
	input lc3b_pkg::lc3b_reg waddr,
	input lc3b_pkg::lc3b_word wdata,
	input lc3b_pkg::lc3b_reg raddr_a,
	input lc3b_pkg::lc3b_reg raddr_b,
	output lc3b_pkg::lc3b_word rdata_a,
	output lc3b_pkg::lc3b_word rdata_b
);
	import lc3b_pkg::*;

	lc3b_word regs [`LC3B_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// write-through so decode sees the retiring result
	always_comb begin
		rdata_a = regs[raddr_a];
		rdata_b = regs[raddr_b];
		if (we && (waddr == raddr_a)) begin
			rdata_a = wdata;
		end
		if (we && (waddr == raddr_b)) begin
			rdata_b = wdata;
		end
	end

	a_waddr_known: assert property (
		@(posedge clk) disable iff (!rst_n) we |-> !$isunknown(waddr)
	) else $error("regfile write with unknown address");

endmodule

/* verification/lc3b_core_tb.sv */
`timescale 1ns/1ps

module lc3b_core_tb;

	localparam int clk_period = 100;
	localparam int drive_dly = 1;
	// 8 + 12 + 39 + 112 + 47 + 300 strobes over the six tests
	localparam int total_strobes = 518;
	localparam int watchdog_cycles = total_strobes * 3 + 200;

	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_shf = 4'b1101;

	logic clk;
	logic rst_n;
	logic instr_valid;
	logic [15:0] instr;
	logic wb_valid;
	logic [2:0] wb_dest;
	logic [15:0] wb_data;
	logic [2:0] cc;

	integer seed;
	int cyc = 0;
	logic [15:0] model_regs [8];
	logic [2:0] retired_cc;
	int due_q [$];
	logic [2:0] dest_q [$];
	logic [15:0] data_q [$];
	logic [2:0] cc_q [$];

	lc3b_core u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.cc(cc)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [15:0] rr_instr(logic [3:0] opc, logic [2:0] dr, logic [2:0] sr1,
		logic [2:0] sr2);
		return {opc, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic logic [15:0] ri_instr(logic [3:0] opc, logic [2:0] dr, logic [2:0] sr1,
		logic [4:0] imm5);
		return {opc, dr, sr1, 1'b1, imm5};
	endfunction

	function automatic logic [15:0] not_instr(logic [2:0] dr, logic [2:0] sr1);
		return {opc_not, dr, sr1, 6'h3f};
	endfunction

	// kind is {arithmetic, right}
	function automatic logic [15:0] shf_instr(logic [2:0] dr, logic [2:0] sr1, logic [1:0] kind,
		logic [3:0] amt);
		return {opc_shf, dr, sr1, kind, amt};
	endfunction

	function automatic logic [2:0] cc_of(logic [15:0] v);
		if (v[15]) begin
			return 3'b100;
		end else if (v == 16'h0000) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
		$display("ERR %s: got %h, expected %h (cycle %0d)", name, got, exp, cyc);
		abort_run();
	endtask

	task automatic complain(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		complain($sformatf("timeout: run did not end within %0d clock periods", watchdog_cycles));
	end

	// strobe one instruction and advance the reference model
	task automatic issue(input logic [15:0] ins);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic supported;
		@(posedge clk);
		#drive_dly;
		instr_valid = 1'b1;
		instr = ins;
		a = model_regs[ins[8:6]];
		if (ins[5]) begin
			b = {{11{ins[4]}}, ins[4:0]};
		end else begin
			b = model_regs[ins[2:0]];
		end
		supported = 1'b1;
		case (ins[15:12])
			opc_add: res = a + b;
			opc_and: res = a & b;
			opc_not: res = ~a;
			opc_shf: begin
				if (!ins[4]) begin
					res = a << ins[3:0];
				end else if (ins[5]) begin
					// vacated upper bits take copies of the sign bit
					res = (a >> ins[3:0]) | ({16{a[15]}} & ~(16'hffff >> ins[3:0]));
				end else begin
					res = a >> ins[3:0];
				end
			end
			default: begin
				res = a;
				supported = 1'b0;
			end
		endcase
		if (supported) begin
			model_regs[ins[11:9]] = res;
			due_q.push_back(cyc + 2);
			dest_q.push_back(ins[11:9]);
			data_q.push_back(res);
			cc_q.push_back(cc_of(res));
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#drive_dly;
			instr_valid = 1'b0;
		end
	endtask

	task automatic check_writeback();
		logic expect_wb;
		expect_wb = 1'b0;
		if (due_q.size() > 0) begin
			expect_wb = (due_q[0] == cyc);
		end
		if (expect_wb) begin
			assert (wb_valid === 1'b1) else mismatch("wb_valid", {15'd0, wb_valid}, 16'h0001);
			assert (wb_dest === dest_q[0])
				else mismatch("wb_dest", {13'd0, wb_dest}, {13'd0, dest_q[0]});
			assert (wb_data === data_q[0]) else mismatch("wb_data", wb_data, data_q[0]);
			retired_cc = cc_q[0];
			void'(due_q.pop_front());
			void'(dest_q.pop_front());
			void'(data_q.pop_front());
			void'(cc_q.pop_front());
		end else begin
			assert (wb_valid === 1'b0) else mismatch("wb_valid", {15'd0, wb_valid}, 16'h0000);
		end
		assert (cc === retired_cc) else mismatch("cc", {13'd0, cc}, {13'd0, retired_cc});
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			check_writeback();
		end
	end

	// nibble by nibble through ADD imm and LSHF 4
	task automatic load_const(input logic [2:0] dr, input logic [15:0] value);
		int n;
		issue(ri_instr(opc_and, dr, dr, 5'h00));
		for (n = 3; n >= 0; n--) begin
			issue(ri_instr(opc_add, dr, dr, {1'b0, value[4*n +: 4]}));
			if (n > 0) begin
				issue(shf_instr(dr, dr, 2'b00, 4'd4));
			end
		end
	endtask

	task automatic reset_state_test();
		int r;
		repeat (3) begin
			@(negedge clk);
			assert (wb_valid === 1'b0) else mismatch("wb_valid", {15'd0, wb_valid}, 16'h0000);
			assert (cc === 3'b010) else mismatch("cc", {13'd0, cc}, 16'h0002);
		end
		// FFFF from each register shows it was cleared
		for (r = 0; r < 8; r++) begin
			issue(not_instr(3'(r), 3'(r)));
		end
		idle(3);
	endtask

	task automatic arithmetic_test();
		logic [15:0] prog [12];
		int i;
		prog[0] = ri_instr(opc_and, 3'd0, 3'd0, 5'h00);
		prog[1] = ri_instr(opc_add, 3'd1, 3'd0, 5'h05);
		prog[2] = ri_instr(opc_add, 3'd2, 3'd0, 5'h1d);
		prog[3] = rr_instr(opc_add, 3'd3, 3'd1, 3'd2);
		prog[4] = rr_instr(opc_and, 3'd4, 3'd2, 3'd1);
		prog[5] = ri_instr(opc_and, 3'd5, 3'd2, 5'h1c);
		prog[6] = not_instr(3'd6, 3'd1);
		prog[7] = ri_instr(opc_add, 3'd7, 3'd6, 5'h0f);
		prog[8] = not_instr(3'd0, 3'd6);
		prog[9] = rr_instr(opc_add, 3'd1, 3'd1, 3'd2);
		prog[10] = ri_instr(opc_add, 3'd2, 3'd2, 5'h10);
		prog[11] = ri_instr(opc_and, 3'd3, 3'd7, 5'h1f);
		for (i = 0; i < 12; i++) begin
			issue(prog[i]);
			idle(2);
		end
	endtask

	task automatic forwarding_test();
		int g;
		for (g = 0; g < 3; g++) begin
			issue(ri_instr(opc_add, 3'd1, 3'd1, 5'h07));
			idle(g);
			issue(ri_instr(opc_add, 3'd2, 3'd1, 5'h1e));
			idle(g);
			issue(rr_instr(opc_add, 3'd3, 3'd0, 3'd2));
			idle(g);
			issue(rr_instr(opc_and, 3'd4, 3'd3, 3'd3));
			idle(g);
			issue(not_instr(3'd5, 3'd4));
			idle(g);
			issue(shf_instr(3'd6, 3'd5, 2'b11, 4'd3));
			idle(g);
			// newer of two R7 writers must win
			issue(ri_instr(opc_add, 3'd7, 3'd6, 5'h0b));
			issue(ri_instr(opc_add, 3'd7, 3'd7, 5'h1a));
			idle(g);
			issue(rr_instr(opc_add, 3'd1, 3'd7, 3'd7));
			idle(g);
			// low imm bits name the previous dest but are no source
			issue(not_instr(3'd2, 3'd6));
			issue(ri_instr(opc_add, 3'd3, 3'd0, 5'h02));
			issue(ri_instr(opc_and, 3'd4, 3'd2, 5'h0b));
			issue(shf_instr(3'd5, 3'd0, 2'b00, 4'd4));
			idle(3);
		end
	endtask

	task automatic shift_test();
		logic [15:0] vals [2];
		logic [1:0] kinds [3];
		int v;
		int amt;
		int k;
		vals = '{16'hb6c5, 16'h4e39};
		// lshf, rshfl, rshfa
		kinds = '{2'b00, 2'b01, 2'b11};
		for (v = 0; v < 2; v++) begin
			load_const(3'd1, vals[v]);
			for (amt = 0; amt < 16; amt++) begin
				for (k = 0; k < 3; k++) begin
					issue(shf_instr(3'(k + 2), 3'd1, kinds[k], 4'(amt)));
				end
			end
		end
		idle(3);
	endtask

	task automatic unsupported_test();
		logic [3:0] bad [12];
		int i;
		bad = '{4'b0000, 4'b0010, 4'b0011, 4'b0100, 4'b0110, 4'b0111,
			4'b1000, 4'b1010, 4'b1011, 4'b1100, 4'b1110, 4'b1111};
		load_const(3'd1, 16'h1234);
		for (i = 0; i < 12; i++) begin
			issue({bad[i], 3'd1, 3'd1, 6'h3f});
			issue(not_instr(3'd2, 3'd1));
		end
		// producer, dropped LDR to the same register, consumer
		issue(ri_instr(opc_add, 3'd3, 3'd1, 5'h01));
		issue({4'b0110, 3'd3, 3'd3, 6'h00});
		issue(rr_instr(opc_add, 3'd4, 3'd3, 3'd3));
		idle(2);
		for (i = 0; i < 4; i++) begin
			issue({bad[11 - i], 3'(i), 3'd2, 6'h15});
		end
		idle(2);
		for (i = 0; i < 8; i++) begin
			issue(ri_instr(opc_add, 3'(i), 3'(i), 5'h00));
		end
		idle(3);
	endtask

	task automatic random_test();
		logic [3:0] supported_ops [4];
		logic [31:0] r;
		logic [15:0] ins;
		logic [1:0] gap;
		int i;
		supported_ops = '{opc_add, opc_and, opc_not, opc_shf};
		for (i = 0; i < 300; i++) begin
			r = $random(seed);
			ins = r[15:0];
			// three in four get a supported opcode
			if (r[17:16] != 2'b00) begin
				ins[15:12] = supported_ops[r[19:18]];
			end
			if (ins[15:12] == opc_not) begin
				ins[5:0] = 6'h3f;
			end else if ((ins[15:12] == opc_add || ins[15:12] == opc_and) && !ins[5]) begin
				ins[4:3] = 2'b00;
			end
			issue(ins);
			gap = r[21:20];
			if (gap == 2'b11) begin
				gap = 2'b00;
			end
			idle(int'(gap));
		end
		idle(3);
	endtask

	initial begin
		int i;
		seed = 32'hc33c;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = 16'h0000;
		retired_cc = 3'b010;
		for (i = 0; i < 8; i++) begin
			model_regs[i] = 16'h0000;
		end
		repeat (10) @(posedge clk);
		#drive_dly;
		rst_n = 1'b1;
		reset_state_test();
		arithmetic_test();
		forwarding_test();
		shift_test();
		unsupported_test();
		random_test();
		if (due_q.size() != 0) begin
			complain("write-backs still expected after the last instruction");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule
